// ==== verilog/rop_pkg.sv ====
package rop_pkg;

    // Frame geometry
    localparam int MAX_COLS   = 8;
    localparam int FRAME_ROWS = 6;
    localparam int COL_WIDTH  = $clog2(MAX_COLS);
    localparam int ROW_WIDTH  = $clog2(FRAME_ROWS);

    // Horizontal count 0..3, neighbourhood count 0..9
    localparam int COUNT_WIDTH = 2;
    localparam int SUM_WIDTH   = 4;

    // Credit budgets
    localparam int IN_CREDITS   = 4;
    localparam int OUT_CREDITS  = 4;
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);

    // Cycles without a pop after an end-of-line pixel
    localparam int ROW_GAP = 2;

    typedef logic [MAX_COLS-1:0][COUNT_WIDTH-1:0] count_row_t;
    typedef logic [MAX_COLS-1:0]                  mask_row_t;

    typedef struct packed {
        logic mark;
        logic eol;
    } pix_t;

    // Horizontal result for one column, with that column's own mark
    typedef struct packed {
        logic                   valid;
        logic                   last;
        logic                   mark;
        logic [COUNT_WIDTH-1:0] count;
    } adj_col_t;

    typedef struct packed {
        logic [ROW_WIDTH-1:0] row;
        logic [COL_WIDTH-1:0] col;
        logic                 mark;
        logic [SUM_WIDTH-1:0] count;
    } rop_result_t;

endpackage

// ==== verilog/pix_credit_fifo.sv ====
`timescale 1ns/1ps

module pix_credit_fifo
    import rop_pkg::*;
#(
    parameter int depth = IN_CREDITS
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  pix_t in_pix,
    input  logic pop,
    output pix_t head,
    output logic not_empty,
    output logic in_credit
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    pix_t mem [depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic full;
    logic wr_en;
    logic rd_en;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == cnt_t'(depth));
    assign not_empty = (count != '0);
    assign wr_en     = in_valid && !full;
    assign rd_en     = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back to the source per popped pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= rd_en;
        end
    end

endmodule

// ==== verilog/out_credit_gate.sv ====
`timescale 1ns/1ps

module out_credit_gate
    import rop_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic not_empty,
    input  logic head_eol,
    input  logic out_credit,
    output logic pop
);

    logic [CREDIT_WIDTH-1:0] credits;
    logic [1:0]              gap;
    logic [ROW_WIDTH-1:0]    row;
    logic                    row_zero;
    logic                    consume;

    // Row 0 of a frame produces no results, so it needs no credit
    assign row_zero = (row == '0);
    assign pop      = not_empty && (gap == '0) && (row_zero || credits != '0);
    assign consume  = pop && !row_zero;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_WIDTH'(OUT_CREDITS);
        end else begin
            case ({out_credit, consume})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Row-end gap and frame row tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gap <= '0;
            row <= '0;
        end else if (pop && head_eol) begin
            gap <= 2'(ROW_GAP);
            row <= (row == ROW_WIDTH'(FRAME_ROWS - 1)) ? '0 : row + 1'b1;
        end else if (gap != '0) begin
            gap <= gap - 1'b1;
        end
    end

endmodule

// ==== verilog/adj_col_counter.sv ====
`timescale 1ns/1ps

module adj_col_counter
    import rop_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pix_valid,
    input  pix_t     pix,
    output adj_col_t adj_col
);

    logic pix_q_valid;
    pix_t pix_q;
    logic left_mark;
    logic mid_mark;
    logic first;
    logic flush;

    // Input stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_q_valid <= 1'b0;
        end else begin
            pix_q_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            pix_q <= pix;
        end
    end

    // Mark history, left of column 0 reads as unmarked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_mark <= 1'b0;
            mid_mark  <= 1'b0;
            first     <= 1'b1;
            flush     <= 1'b0;
        end else if (pix_q_valid) begin
            left_mark <= first ? 1'b0 : mid_mark;
            mid_mark  <= pix_q.mark;
            first     <= pix_q.eol;
            flush     <= pix_q.eol;
        end else begin
            flush <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adj_col <= '0;
        end else if (pix_q_valid && !first) begin
            adj_col.valid <= 1'b1;
            adj_col.last  <= 1'b0;
            adj_col.mark  <= mid_mark;
            adj_col.count <= COUNT_WIDTH'(left_mark) + COUNT_WIDTH'(mid_mark)
                           + COUNT_WIDTH'(pix_q.mark);
        end else if (flush) begin
            // Last column, right of it is outside the frame
            adj_col.valid <= 1'b1;
            adj_col.last  <= 1'b1;
            adj_col.mark  <= mid_mark;
            adj_col.count <= COUNT_WIDTH'(left_mark) + COUNT_WIDTH'(mid_mark);
        end else begin
            adj_col.valid <= 1'b0;
            adj_col.last  <= 1'b0;
        end
    end

endmodule

// ==== verilog/prev_row_stores.sv ====
`timescale 1ns/1ps

module prev_row_stores
    import rop_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  adj_col_t             adj_col,
    output logic [ROW_WIDTH-1:0] row_index,
    output logic                 next_row,
    output count_row_t           upper_row_rop_count,
    output count_row_t           center_row_rop_count,
    output mask_row_t            center_row_rop_mask
);

    count_row_t           hot_row_rop_count;
    mask_row_t            hot_row_mask;
    logic [COL_WIDTH-1:0] hot_col;
    logic                 shift_pending;

    // Hot row filled at a running column index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hot_row_rop_count <= '0;
            hot_row_mask      <= '0;
            hot_col           <= '0;
        end else if (adj_col.valid) begin
            hot_row_rop_count[hot_col] <= adj_col.count;
            hot_row_mask[hot_col]      <= adj_col.mark;
            if (adj_col.last) begin
                hot_col <= '0;
            end else begin
                hot_col <= hot_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_pending <= 1'b0;
        end else begin
            shift_pending <= adj_col.valid && adj_col.last;
        end
    end

    // Hot to centre to upper, one cycle after the row's last result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_index            <= '0;
            next_row             <= 1'b0;
            upper_row_rop_count  <= '0;
            center_row_rop_count <= '0;
            center_row_rop_mask  <= '0;
        end else if (shift_pending) begin
            next_row             <= 1'b1;
            center_row_rop_count <= hot_row_rop_count;
            center_row_rop_mask  <= hot_row_mask;
            // New centre is the frame's top row
            if (row_index == '0) begin
                upper_row_rop_count <= '0;
            end else begin
                upper_row_rop_count <= center_row_rop_count;
            end
            if (row_index == ROW_WIDTH'(FRAME_ROWS - 1)) begin
                row_index <= '0;
            end else begin
                row_index <= row_index + 1'b1;
            end
        end else begin
            next_row <= 1'b0;
        end
    end

endmodule

// ==== verilog/neighbor_sum.sv ====
`timescale 1ns/1ps

module neighbor_sum
    import rop_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  adj_col_t             adj_col,
    input  logic [ROW_WIDTH-1:0] row_index,
    input  logic                 next_row,
    input  count_row_t           upper_row_rop_count,
    input  count_row_t           center_row_rop_count,
    input  mask_row_t            center_row_rop_mask,
    output logic                 out_valid,
    output rop_result_t          out_result
);

    logic [COL_WIDTH-1:0] low_col;
    logic [SUM_WIDTH-1:0] sum;
    logic                 has_center;

    // Column of the lower row, restarted by each row shift
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            low_col <= '0;
        end else if (next_row) begin
            low_col <= '0;
        end else if (adj_col.valid) begin
            low_col <= low_col + 1'b1;
        end
    end

    assign sum = SUM_WIDTH'(upper_row_rop_count[low_col])
               + SUM_WIDTH'(center_row_rop_count[low_col])
               + SUM_WIDTH'(adj_col.count);

    // Incoming row 0 has no centre row above it
    assign has_center = (row_index != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= adj_col.valid && has_center;
        end
    end

    always_ff @(posedge clk) begin
        if (adj_col.valid) begin
            out_result.row   <= row_index - 1'b1;
            out_result.col   <= low_col;
            out_result.mark  <= center_row_rop_mask[low_col];
            out_result.count <= sum;
        end
    end

endmodule

// ==== verilog/rop_filter_top.sv ====
`timescale 1ns/1ps

module rop_filter_top
    import rop_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  pix_t        in_pix,
    output logic        in_credit,
    input  logic        out_credit,
    output logic        out_valid,
    output rop_result_t out_result
);

    pix_t                 fifo_head;
    logic                 fifo_not_empty;
    logic                 pop;
    adj_col_t             adj_col;
    logic [ROW_WIDTH-1:0] row_index;
    logic                 next_row;
    count_row_t           upper_row_rop_count;
    count_row_t           center_row_rop_count;
    mask_row_t            center_row_rop_mask;

    pix_credit_fifo #(
        .depth(IN_CREDITS)
    ) i_in_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .pop       (pop),
        .head      (fifo_head),
        .not_empty (fifo_not_empty),
        .in_credit (in_credit)
    );

    out_credit_gate i_gate (
        .clk        (clk),
        .rst_n      (rst_n),
        .not_empty  (fifo_not_empty),
        .head_eol   (fifo_head.eol),
        .out_credit (out_credit),
        .pop        (pop)
    );

    adj_col_counter i_adj (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pop),
        .pix       (fifo_head),
        .adj_col   (adj_col)
    );

    prev_row_stores i_rows (
        .clk                  (clk),
        .rst_n                (rst_n),
        .adj_col              (adj_col),
        .row_index            (row_index),
        .next_row             (next_row),
        .upper_row_rop_count  (upper_row_rop_count),
        .center_row_rop_count (center_row_rop_count),
        .center_row_rop_mask  (center_row_rop_mask)
    );

    neighbor_sum i_sum (
        .clk                  (clk),
        .rst_n                (rst_n),
        .adj_col              (adj_col),
        .row_index            (row_index),
        .next_row             (next_row),
        .upper_row_rop_count  (upper_row_rop_count),
        .center_row_rop_count (center_row_rop_count),
        .center_row_rop_mask  (center_row_rop_mask),
        .out_valid            (out_valid),
        .out_result           (out_result)
    );

endmodule

// ==== verif/rop_filter_asserts.sv ====
`timescale 1ns/1ps

module rop_filter_asserts
    import rop_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic pop,
    input logic next_row,
    input logic out_credit,
    input logic out_valid
);

    int fifo_fill;
    int sink_credits;

    // Input FIFO level and output credits as seen from the ports
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fifo_fill    <= 0;
            sink_credits <= OUT_CREDITS;
        end else begin
            fifo_fill    <= fifo_fill + int'(in_valid) - int'(pop);
            sink_credits <= sink_credits + int'(out_credit) - int'(out_valid);
        end
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> fifo_fill < IN_CREDITS)
        else $error("input FIFO written while full");

    single_row_shift: assert property (@(posedge clk) disable iff (!rst_n)
        next_row |=> !next_row)
        else $error("next_row high on two consecutive cycles");

    result_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> sink_credits > 0)
        else $error("result sent without an output credit");

endmodule

// ==== verif/rop_filter_checker.sv ====
`timescale 1ns/1ps

module rop_filter_checker
    import rop_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  pix_t        in_pix,
    input  logic        out_valid,
    input  rop_result_t out_result,
    output int          result_count,
    output int          error_count
);

    localparam int FRAME_PIXELS  = FRAME_ROWS * MAX_COLS;
    localparam int FRAME_RESULTS = (FRAME_ROWS - 1) * MAX_COLS;

    // Every mark sent, raster order across frames
    logic  marks [$];
    string test_name = "reset";

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    function automatic int mark_at(input int frame, input int row, input int col);
        int idx;
        if (row < 0 || row >= FRAME_ROWS || col < 0 || col >= MAX_COLS) begin
            return 0;
        end
        idx = frame * FRAME_PIXELS + row * MAX_COLS + col;
        return (idx < marks.size()) ? int'(marks[idx]) : 0;
    endfunction

    task automatic compare(input rop_result_t got, output int errs);
        int frame, row, col, exp_count;
        frame     = result_count / FRAME_RESULTS;
        row       = (result_count % FRAME_RESULTS) / MAX_COLS;
        col       = result_count % MAX_COLS;
        exp_count = 0;
        errs      = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                exp_count = exp_count + mark_at(frame, row + dr, col + dc);
            end
        end
        if (int'(got.row) != row || int'(got.col) != col) begin
            $display("error %s: result %0d position expected %0d/%0d actual %0d/%0d",
                     test_name, result_count, row, col, got.row, got.col);
            errs = errs + 1;
        end
        if (int'(got.count) != exp_count) begin
            $display("error %s: result %0d count expected %0d actual %0d",
                     test_name, result_count, exp_count, got.count);
            errs = errs + 1;
        end
        if (int'(got.mark) != mark_at(frame, row, col)) begin
            $display("error %s: result %0d mark expected %0d actual %0d",
                     test_name, result_count, mark_at(frame, row, col), got.mark);
            errs = errs + 1;
        end
    endtask

    always @(posedge clk) begin
        int errs;
        if (!rst_n) begin
            marks.delete();
            result_count <= 0;
            error_count  <= 0;
        end else begin
            if (in_valid) begin
                marks.push_back(in_pix.mark);
            end
            if (out_valid) begin
                compare(out_result, errs);
                result_count <= result_count + 1;
                error_count  <= error_count + errs;
            end
        end
    end

endmodule

// ==== verif/tb_rop_filter.sv ====
`timescale 1ns/1ps

module tb_rop_filter
    import rop_pkg::*;
();

    localparam int FRAME_PIXELS  = FRAME_ROWS * MAX_COLS;
    localparam int FRAME_RESULTS = (FRAME_ROWS - 1) * MAX_COLS;
    // Sum of the frames sent by all tests below
    localparam int TOTAL_FRAMES  = 15;
    localparam int WATCHDOG_NS   = TOTAL_FRAMES * FRAME_PIXELS * 20 * 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    pix_t        in_pix;
    logic        in_credit;
    logic        out_credit = 1'b0;
    logic        out_valid;
    rop_result_t out_result;
    int          checked_results;
    int          check_errors;
    integer      seed = 32'hdcdbfcc3;
    int          pixels_sent = 0;
    int          credit_returns = 0;
    int          sink_owed = 0;
    int          sink_hold = 0;
    int          sink_mode = 0;
    int          tb_errors = 0;
    int          failed_tests = 0;

    rop_filter_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_pix     (in_pix),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    rop_filter_checker i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_pix       (in_pix),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .result_count (checked_results),
        .error_count  (check_errors)
    );

    bind rop_filter_top rop_filter_asserts i_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .pop        (pop),
        .next_row   (next_row),
        .out_credit (out_credit),
        .out_valid  (out_valid)
    );

    always #10 clk = ~clk;

    function automatic int rand_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    always @(posedge clk) begin
        if (in_credit) begin
            credit_returns <= credit_returns + 1;
        end
    end

    // Sink returns one credit per result after a delay set by the test
    always @(posedge clk) begin
        if (out_valid) begin
            sink_owed = sink_owed + 1;
        end
        #1;
        if (sink_owed > 0 && sink_hold == 0) begin
            out_credit = 1'b1;
            sink_owed  = sink_owed - 1;
            sink_hold  = (sink_mode == 2) ? rand_below(64) : (sink_mode == 1) ? rand_below(4) : 0;
        end else begin
            out_credit = 1'b0;
            if (sink_hold > 0) begin
                sink_hold = sink_hold - 1;
            end
        end
    end

    task automatic send_frame(input int mark_pct, input int idle_pct);
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            @(posedge clk);
            #1;
            while (pixels_sent - credit_returns >= IN_CREDITS || rand_below(100) < idle_pct) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_valid    = 1'b1;
            in_pix.mark = rand_below(100) < mark_pct;
            in_pix.eol  = (p % MAX_COLS == MAX_COLS - 1);
            pixels_sent = pixels_sent + 1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int frames, input int mark_pct,
                            input int idle_pct, input int mode);
        int errors_before;
        int target;
        errors_before = check_errors + tb_errors;
        target        = checked_results + frames * FRAME_RESULTS;
        sink_mode     = mode;
        i_checker.begin_test(name);
        repeat (frames) send_frame(mark_pct, idle_pct);
        while (checked_results < target) @(posedge clk);
        repeat (40) @(posedge clk);
        if (checked_results != target) begin
            $display("error %s: result count expected %0d actual %0d",
                     name, target, checked_results);
            tb_errors = tb_errors + 1;
        end
        if (credit_returns != pixels_sent) begin
            $display("error %s: input credits expected %0d actual %0d",
                     name, pixels_sent, credit_returns);
            tb_errors = tb_errors + 1;
        end
        if (check_errors + tb_errors == errors_before) begin
            $display("test %s passed, %0d results so far", name, checked_results);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %s failed", name);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_pix   = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_test("sparse_frames", 3, 20, 20, 1);
        run_test("edge_frames", 3, 100, 0, 1);
        run_test("back_pressure", 3, 30, 10, 2);
        run_test("input_credits", 2, 50, 0, 0);
        run_test("frame_sequencing", 4, 20, 0, 1);
        $display("5 tests, %0d failed, %0d results checked, %0d errors",
                 failed_tests, checked_results, check_errors + tb_errors);
        if (failed_tests == 0 && check_errors + tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, %0d results checked",
                 WATCHDOG_NS, checked_results);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== rop_filter_top.f ====
verilog/rop_pkg.sv
verilog/pix_credit_fifo.sv
verilog/out_credit_gate.sv
verilog/adj_col_counter.sv
verilog/prev_row_stores.sv
verilog/neighbor_sum.sv
verilog/rop_filter_top.sv
verif/rop_filter_asserts.sv
verif/rop_filter_checker.sv
verif/tb_rop_filter.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rop_filter -f rop_filter_top.f

status=0
output=$(./obj_dir/Vtb_rop_filter) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "simulation did not pass"
exit 1
